// File: Makefile
TOP := tb_nettlp_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f nettlp_bridge.f -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/eth_tlp_extract.sv
`default_nettype none
`timescale 1ns/1ps
`include "nettlp_defs.svh"

module eth_tlp_extract (
	input  wire                          pcie_clk,
	input  wire                          pcie_rst,

	// Ethernet receive stream
	input  wire                          eth_tvalid,
	output logic                         eth_tready,
	input  wire [`NETTLP_DATA_WIDTH-1:0] eth_tdata,
	input  wire [`NETTLP_KEEP_WIDTH-1:0] eth_tkeep,
	input  wire                          eth_tlast,

	// Packet FIFO write side
	input  wire                          full,
	output logic                         wr_en,
	output nettlp_pkg::pcie_fifo_word_t  din,

	output logic                         fifo_read_req // One pulse per good packet
);
	import nettlp_pkg::*;

	extract_state_e state;
	logic [2:0]     word_cnt;   // Header word index, 0 to 5
	logic           hdr_match;  // EtherType and UDP port both matched so far
	logic           rx_enable;
	logic           beat;
	logic           last_hdr_word;
	logic [15:0]    hdr_field;

	// Ready stays low until the cycle after reset ends
	always_ff @(posedge pcie_clk) begin
		if (pcie_rst)
			rx_enable <= 1'b0;
		else
			rx_enable <= 1'b1;
	end

	assign eth_tready = rx_enable && !full;
	assign beat       = eth_tvalid && eth_tready;

	assign last_hdr_word = (word_cnt == `NETTLP_HDR_WORDS - 1);

	// Bytes 4 and 5 of the word, high byte first as on the wire
	// EtherType lands here in word 1 and the UDP destination port in word 4
	assign hdr_field = {eth_tdata[39:32], eth_tdata[47:40]};

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst) begin
			hdr_match <= 1'b0;
		end else if (beat && state == HDR) begin
			if (word_cnt == 3'd1)
				hdr_match <= (hdr_field == `NETTLP_ETHERTYPE);
			else if (word_cnt == 3'd4)
				hdr_match <= hdr_match && (hdr_field == `NETTLP_UDP_PORT);
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst) begin
			state         <= HDR;
			word_cnt      <= '0;
			fifo_read_req <= 1'b0;
		end else begin
			fifo_read_req <= 1'b0;

			if (beat) begin
				case (state)
				HDR: begin
					if (eth_tlast) begin
						word_cnt <= '0; // Frame ended inside the header
					end else if (last_hdr_word) begin
						word_cnt <= '0;
						state    <= hdr_match ? PAYLOAD : DROP;
					end else begin
						word_cnt <= word_cnt + 3'd1;
					end
				end
				PAYLOAD: begin
					if (eth_tlast) begin
						state         <= HDR;
						fifo_read_req <= 1'b1; // Whole packet is now in the FIFO
					end
				end
				DROP: begin
					if (eth_tlast)
						state <= HDR;
				end
				default: begin
					state <= HDR;
				end
				endcase
			end
		end
	end

	// Payload goes to the FIFO in the same cycle it is accepted
	assign wr_en = beat && (state == PAYLOAD);

	always_comb begin
		din        = '0;
		din.tvalid = eth_tvalid;
		din.tlast  = eth_tlast;
		din.tkeep  = eth_tkeep;  // Keeps the byte enables of a short last word
		din.tdata  = eth_tdata;
	end

endmodule

`default_nettype wire

// File: design/fifo2pcie.sv
`default_nettype none
`timescale 1ns/1ps
`include "nettlp_defs.svh"

module fifo2pcie (
	input  wire                          pcie_clk,
	input  wire                          pcie_rst,

	// Packet FIFO read side
	output logic                         rd_en,
	input  wire nettlp_pkg::pcie_fifo_word_t dout,
	input  wire                          empty,

	input  wire                          fifo_read_req, // A complete packet was queued

	// Transmit port request and grant
	output logic                         pcie_tx_req,
	input  wire                          pcie_tx_ack,

	// The link has to take every beat, so tready is not looked at
	input  wire                          pcie_tready,

	// TLP stream towards the arbiter
	output logic                         pcie_tvalid,
	output logic                         pcie_tlast,
	output logic [`NETTLP_KEEP_WIDTH-1:0] pcie_tkeep,
	output logic [`NETTLP_DATA_WIDTH-1:0] pcie_tdata
);
	import nettlp_pkg::*;

	drain_state_e state;
	drain_state_e state_next;
	logic [7:0]   eth_pktcount; // Packets written into the FIFO
	logic [7:0]   tlp_pktcount; // Packets sent out

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst)
			eth_pktcount <= '0;
		else if (fifo_read_req)
			eth_pktcount <= eth_pktcount + 8'd1;
	end

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst)
			tlp_pktcount <= '0;
		else if (state == READ && dout.tlast)
			tlp_pktcount <= tlp_pktcount + 8'd1;
	end

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next  = state;
		rd_en       = 1'b0;
		pcie_tx_req = 1'b0;
		pcie_tvalid = 1'b0;
		pcie_tlast  = 1'b0;
		pcie_tkeep  = '0;
		pcie_tdata  = '0;

		case (state)
		IDLE: begin
			if (tlp_pktcount != eth_pktcount) begin
				pcie_tx_req = 1'b1;
				if (pcie_tx_ack && !empty)
					state_next = READ;
			end
		end
		READ: begin
			// The whole packet is already queued so every cycle carries a beat
			rd_en       = 1'b1;
			pcie_tx_req = 1'b1;
			pcie_tvalid = dout.tvalid;
			pcie_tlast  = dout.tlast;
			pcie_tkeep  = dout.tkeep;
			pcie_tdata  = dout.tdata;
			if (dout.tlast)
				state_next = IDLE;
		end
		default: begin
			state_next = IDLE;
		end
		endcase
	end

endmodule

`default_nettype wire

// File: design/nettlp_bridge.sv
`default_nettype none
`timescale 1ns/1ps
`include "nettlp_defs.svh"

module nettlp_bridge (
	input  wire                           pcie_clk,
	input  wire                           pcie_rst,

	// Ethernet receive stream
	input  wire                           eth_tvalid,
	output logic                          eth_tready,
	input  wire [`NETTLP_DATA_WIDTH-1:0]  eth_tdata,
	input  wire [`NETTLP_KEEP_WIDTH-1:0]  eth_tkeep,
	input  wire                           eth_tlast,

	// External transmit requester
	input  wire                           ext_tx_req,
	output logic                          ext_tx_ack,
	input  wire                           ext_tvalid,
	input  wire                           ext_tlast,
	input  wire [`NETTLP_KEEP_WIDTH-1:0]  ext_tkeep,
	input  wire [`NETTLP_DATA_WIDTH-1:0]  ext_tdata,

	// PCIe transmit link
	input  wire                           pcie_tready,
	output logic                          pcie_tvalid,
	output logic                          pcie_tlast,
	output logic [`NETTLP_KEEP_WIDTH-1:0] pcie_tkeep,
	output logic [`NETTLP_DATA_WIDTH-1:0] pcie_tdata
);
	import nettlp_pkg::*;

	logic                          wr_en;
	pcie_fifo_word_t               din;
	logic                          full;
	logic                          rd_en;
	pcie_fifo_word_t               dout;
	logic                          empty;
	logic                          fifo_read_req;
	logic                          bridge_tx_req;
	logic                          bridge_tx_ack;
	logic                          bridge_tvalid;
	logic                          bridge_tlast;
	logic [`NETTLP_KEEP_WIDTH-1:0] bridge_tkeep;
	logic [`NETTLP_DATA_WIDTH-1:0] bridge_tdata;

	eth_tlp_extract i_eth_tlp_extract (
		.pcie_clk      (pcie_clk),
		.pcie_rst      (pcie_rst),
		.eth_tvalid    (eth_tvalid),
		.eth_tready    (eth_tready),
		.eth_tdata     (eth_tdata),
		.eth_tkeep     (eth_tkeep),
		.eth_tlast     (eth_tlast),
		.full          (full),
		.wr_en         (wr_en),
		.din           (din),
		.fifo_read_req (fifo_read_req)
	);

	tlp_fifo i_tlp_fifo (
		.pcie_clk (pcie_clk),
		.pcie_rst (pcie_rst),
		.wr_en    (wr_en),
		.din      (din),
		.full     (full),
		.rd_en    (rd_en),
		.dout     (dout),
		.empty    (empty)
	);

	fifo2pcie i_fifo2pcie (
		.pcie_clk      (pcie_clk),
		.pcie_rst      (pcie_rst),
		.rd_en         (rd_en),
		.dout          (dout),
		.empty         (empty),
		.fifo_read_req (fifo_read_req),
		.pcie_tx_req   (bridge_tx_req),
		.pcie_tx_ack   (bridge_tx_ack),
		.pcie_tready   (pcie_tready),
		.pcie_tvalid   (bridge_tvalid),
		.pcie_tlast    (bridge_tlast),
		.pcie_tkeep    (bridge_tkeep),
		.pcie_tdata    (bridge_tdata)
	);

	pcie_tx_arbiter i_pcie_tx_arbiter (
		.pcie_clk      (pcie_clk),
		.pcie_rst      (pcie_rst),
		.bridge_tx_req (bridge_tx_req),
		.bridge_tx_ack (bridge_tx_ack),
		.bridge_tvalid (bridge_tvalid),
		.bridge_tlast  (bridge_tlast),
		.bridge_tkeep  (bridge_tkeep),
		.bridge_tdata  (bridge_tdata),
		.ext_tx_req    (ext_tx_req),
		.ext_tx_ack    (ext_tx_ack),
		.ext_tvalid    (ext_tvalid),
		.ext_tlast     (ext_tlast),
		.ext_tkeep     (ext_tkeep),
		.ext_tdata     (ext_tdata),
		.pcie_tvalid   (pcie_tvalid),
		.pcie_tlast    (pcie_tlast),
		.pcie_tkeep    (pcie_tkeep),
		.pcie_tdata    (pcie_tdata)
	);

endmodule

`default_nettype wire

// File: design/nettlp_defs.svh
`ifndef NETTLP_DEFS_SVH
`define NETTLP_DEFS_SVH

// Stream widths shared by the Ethernet side and the PCIe side
`define NETTLP_DATA_WIDTH 64
`define NETTLP_KEEP_WIDTH 8

`define NETTLP_FIFO_DEPTH 512
`define NETTLP_FIFO_AW    9

`define NETTLP_HDR_WORDS  6 // Ethernet, IPv4, UDP and tunnel header in 64-bit words
`define NETTLP_ETHERTYPE  16'h0800
`define NETTLP_UDP_PORT   16'd3000

`endif

// File: design/nettlp_pkg.sv
`default_nettype none
`include "nettlp_defs.svh"

package nettlp_pkg;

	// One word of the packet FIFO
	typedef struct packed {
		logic                          tvalid;
		logic                          tlast;
		logic [`NETTLP_KEEP_WIDTH-1:0] tkeep;
		logic [`NETTLP_DATA_WIDTH-1:0] tdata;
	} pcie_fifo_word_t;

	// Extraction stage walks the header, then keeps or discards the rest
	typedef enum logic [1:0] {
		HDR,
		PAYLOAD,
		DROP
	} extract_state_e;

	typedef enum logic {
		IDLE,
		READ
	} drain_state_e;

	// Current holder of the PCIe transmit port
	typedef enum logic [1:0] {
		NONE,
		BRIDGE,
		EXT
	} arb_owner_e;

endpackage

`default_nettype wire

// File: design/pcie_tx_arbiter.sv
`default_nettype none
`timescale 1ns/1ps
`include "nettlp_defs.svh"

module pcie_tx_arbiter (
	input  wire                           pcie_clk,
	input  wire                           pcie_rst,

	// Bridge side
	input  wire                           bridge_tx_req,
	output logic                          bridge_tx_ack,
	input  wire                           bridge_tvalid,
	input  wire                           bridge_tlast,
	input  wire [`NETTLP_KEEP_WIDTH-1:0]  bridge_tkeep,
	input  wire [`NETTLP_DATA_WIDTH-1:0]  bridge_tdata,

	// External requester
	input  wire                           ext_tx_req,
	output logic                          ext_tx_ack,
	input  wire                           ext_tvalid,
	input  wire                           ext_tlast,
	input  wire [`NETTLP_KEEP_WIDTH-1:0]  ext_tkeep,
	input  wire [`NETTLP_DATA_WIDTH-1:0]  ext_tdata,

	// Shared PCIe transmit link
	output logic                          pcie_tvalid,
	output logic                          pcie_tlast,
	output logic [`NETTLP_KEEP_WIDTH-1:0] pcie_tkeep,
	output logic [`NETTLP_DATA_WIDTH-1:0] pcie_tdata
);
	import nettlp_pkg::*;

	arb_owner_e owner;
	logic       last_ext; // External side won the most recent grant

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst) begin
			owner    <= NONE;
			last_ext <= 1'b0;
		end else begin
			case (owner)
			NONE: begin
				if (bridge_tx_req && (!ext_tx_req || last_ext)) begin
					owner    <= BRIDGE;
					last_ext <= 1'b0;
				end else if (ext_tx_req) begin
					owner    <= EXT;
					last_ext <= 1'b1;
				end
			end
			BRIDGE: begin
				if (!bridge_tx_req)
					owner <= NONE;
			end
			EXT: begin
				if (!ext_tx_req)
					owner <= NONE;
			end
			default: begin
				owner <= NONE;
			end
			endcase
		end
	end

	assign bridge_tx_ack = (owner == BRIDGE);
	assign ext_tx_ack    = (owner == EXT);

	always_comb begin
		pcie_tvalid = 1'b0;
		pcie_tlast  = 1'b0;
		pcie_tkeep  = '0;
		pcie_tdata  = '0;
		case (owner)
		BRIDGE: begin
			pcie_tvalid = bridge_tvalid;
			pcie_tlast  = bridge_tlast;
			pcie_tkeep  = bridge_tkeep;
			pcie_tdata  = bridge_tdata;
		end
		EXT: begin
			pcie_tvalid = ext_tvalid;
			pcie_tlast  = ext_tlast;
			pcie_tkeep  = ext_tkeep;
			pcie_tdata  = ext_tdata;
		end
		default: begin
			pcie_tvalid = 1'b0; // Link stays quiet with no owner
		end
		endcase
	end

endmodule

`default_nettype wire

// File: design/tlp_fifo.sv
`default_nettype none
`timescale 1ns/1ps
`include "nettlp_defs.svh"

module tlp_fifo (
	input  wire                         pcie_clk,
	input  wire                         pcie_rst,

	// Write side
	input  wire                         wr_en,
	input  wire nettlp_pkg::pcie_fifo_word_t din,
	output logic                        full,

	// Read side, head word shows on dout without a read
	input  wire                         rd_en,
	output nettlp_pkg::pcie_fifo_word_t dout,
	output logic                        empty
);
	import nettlp_pkg::*;

	pcie_fifo_word_t mem [0:`NETTLP_FIFO_DEPTH-1];

	// Extra top bit tells a full FIFO from an empty one
	logic [`NETTLP_FIFO_AW:0] wr_ptr;
	logic [`NETTLP_FIFO_AW:0] rd_ptr;
	logic                     do_write;
	logic                     do_read;
	pcie_fifo_word_t          head;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[`NETTLP_FIFO_AW] != rd_ptr[`NETTLP_FIFO_AW]) &&
	               (wr_ptr[`NETTLP_FIFO_AW-1:0] == rd_ptr[`NETTLP_FIFO_AW-1:0]);

	assign do_write = wr_en && !full;
	assign do_read  = rd_en && !empty;

	always_ff @(posedge pcie_clk) begin
		if (do_write)
			mem[wr_ptr[`NETTLP_FIFO_AW-1:0]] <= din;
	end

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign head = mem[rd_ptr[`NETTLP_FIFO_AW-1:0]];

	always_comb begin
		dout = head;
		// Stale memory contents never look like a valid word
		if (empty)
			dout.tvalid = 1'b0;
	end

endmodule

`default_nettype wire

// File: dv/tb_nettlp_bridge.sv
`default_nettype none
`timescale 1ns/1ps
`include "nettlp_defs.svh"

module tb_nettlp_bridge;

	localparam int          NUM_ENTRIES   = 12;
	localparam int          RESET_CYCLES  = 16;
	localparam int          HDR_WORDS     = 6;
	localparam int          TRUNC_WORDS   = 4; // A length of 0 means the frame ends inside the header
	localparam int          SLACK_CYCLES  = 200;
	localparam int          SETTLE_CYCLES = 16;
	localparam int          EXT_BEATS     = 2;
	localparam logic [63:0] EXT_MARK      = 64'he1e1_0000_0000_0000;
	localparam logic [31:0] LFSR_SEED     = 32'he02d657c;

	typedef struct packed {
		logic [15:0] ethertype;
		logic [15:0] udp_port;
		logic [15:0] len;      // Payload length in bytes
		logic        ext_hold; // External requester owns the port while frames arrive
		logic        accept;
		logic [3:0]  copies;   // Frames sent back to back
	} frame_entry_t;

	logic        pcie_clk = 1'b0;
	logic        pcie_rst;
	logic        eth_tvalid;
	logic        eth_tready;
	logic [63:0] eth_tdata;
	logic [7:0]  eth_tkeep;
	logic        eth_tlast;
	logic        ext_tx_req;
	logic        ext_tx_ack;
	logic        ext_tvalid;
	logic        ext_tlast;
	logic [7:0]  ext_tkeep;
	logic [63:0] ext_tdata;
	logic        pcie_tready;
	logic        pcie_tvalid;
	logic        pcie_tlast;
	logic [7:0]  pcie_tkeep;
	logic [63:0] pcie_tdata;

	frame_entry_t frame_table [NUM_ENTRIES];
	logic [72:0]  exp_q [$]; // Expected beats as {tlast, tkeep, tdata}
	logic [72:0]  exp_word;
	logic [31:0]  lfsr = LFSR_SEED;
	int           error_count = 0;
	int           entries_passed = 0;
	int           cycle_count = 0;
	int           timeout_limit = 0;
	logic         saw_stall = 1'b0;
	logic         frames_done = 1'b0;

	nettlp_bridge i_nettlp_bridge (
		.pcie_clk    (pcie_clk),
		.pcie_rst    (pcie_rst),
		.eth_tvalid  (eth_tvalid),
		.eth_tready  (eth_tready),
		.eth_tdata   (eth_tdata),
		.eth_tkeep   (eth_tkeep),
		.eth_tlast   (eth_tlast),
		.ext_tx_req  (ext_tx_req),
		.ext_tx_ack  (ext_tx_ack),
		.ext_tvalid  (ext_tvalid),
		.ext_tlast   (ext_tlast),
		.ext_tkeep   (ext_tkeep),
		.ext_tdata   (ext_tdata),
		.pcie_tready (pcie_tready),
		.pcie_tvalid (pcie_tvalid),
		.pcie_tlast  (pcie_tlast),
		.pcie_tkeep  (pcie_tkeep),
		.pcie_tdata  (pcie_tdata)
	);

	always #2 pcie_clk = ~pcie_clk;

	always @(posedge pcie_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("error: %s expected %h got %h", name, expected, actual);
			error_count++;
		end
	endtask

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		return state >> 1;
	endfunction

	task automatic random_byte(output logic [7:0] value);
		value = '0;
		for (int i = 0; i < 8; i++) begin
			value = {lfsr[0], value[7:1]};
			lfsr  = lfsr_next(lfsr);
		end
	endtask

	function automatic int frame_words(input frame_entry_t entry);
		if (entry.len == 16'd0)
			return TRUNC_WORDS;
		return HDR_WORDS + (int'(entry.len) + 7) / 8;
	endfunction

	// Monitor samples the link half a cycle away from the edges that move it
	always @(negedge pcie_clk) begin
		if (!pcie_rst && pcie_tvalid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected PCIe beat with data %h while no packet was pending",
					pcie_tdata);
				error_count++;
			end else begin
				exp_word = exp_q.pop_front();
				check_value("pcie_tdata", exp_word[63:0], pcie_tdata);
				check_value("pcie_tkeep", 64'(exp_word[71:64]), 64'(pcie_tkeep));
				check_value("pcie_tlast", 64'(exp_word[72]), 64'(pcie_tlast));
			end
		end
	end

	// Called at a rising edge, returns at the edge where the beat transfers
	task automatic drive_word(input logic [63:0] data, input logic [7:0] keep, input logic last);
		eth_tvalid <= 1'b1;
		eth_tdata  <= data;
		eth_tkeep  <= keep;
		eth_tlast  <= last;
		@(negedge pcie_clk);
		while (!eth_tready) begin
			saw_stall = 1'b1;
			@(negedge pcie_clk);
		end
		@(posedge pcie_clk);
	endtask

	task automatic send_frame(input frame_entry_t entry);
		logic [63:0] data;
		logic [7:0]  keep;
		logic [7:0]  rnd;
		int          len;
		int          pay_words;
		int          hdr_words;
		len       = int'(entry.len);
		pay_words = (len + 7) / 8;
		hdr_words = (len == 0) ? TRUNC_WORDS : HDR_WORDS;
		for (int w = 0; w < hdr_words; w++) begin
			data = 64'(w);
			if (w == 1)
				data[47:32] = {entry.ethertype[7:0], entry.ethertype[15:8]}; // Bytes 12 and 13
			if (w == 4)
				data[47:32] = {entry.udp_port[7:0], entry.udp_port[15:8]}; // Bytes 36 and 37
			drive_word(data, 8'hff, pay_words == 0 && w == hdr_words - 1);
		end
		for (int w = 0; w < pay_words; w++) begin
			data = '0;
			keep = '0;
			for (int b = 0; b < 8; b++) begin
				if (w * 8 + b < len) begin
					random_byte(rnd);
					data[b*8 +: 8] = rnd;
					keep[b]        = 1'b1;
				end
			end
			if (entry.accept)
				exp_q.push_back({w == pay_words - 1, keep, data});
			drive_word(data, keep, w == pay_words - 1);
		end
	endtask

	task automatic send_copies(input frame_entry_t entry);
		for (int c = 0; c < int'(entry.copies); c++)
			send_frame(entry);
		eth_tvalid <= 1'b0;
		eth_tlast  <= 1'b0;
		frames_done = 1'b1;
	endtask

	// The external packet closes the hold, so the request drops with its last beat
	task automatic send_ext_packet();
		for (int i = 0; i < EXT_BEATS; i++) begin
			ext_tvalid <= 1'b1;
			ext_tdata  <= EXT_MARK | 64'(i);
			ext_tkeep  <= 8'hff;
			ext_tlast  <= (i == EXT_BEATS - 1);
			@(posedge pcie_clk);
		end
		ext_tvalid <= 1'b0;
		ext_tlast  <= 1'b0;
		ext_tx_req <= 1'b0;
	endtask

	task automatic run_entry(input int num, input frame_entry_t entry);
		int start_errors;
		int pay_words;
		start_errors = error_count;
		pay_words    = (int'(entry.len) + 7) / 8;
		saw_stall    = 1'b0;
		frames_done  = 1'b0;
		@(posedge pcie_clk);
		if (entry.ext_hold) begin
			ext_tx_req <= 1'b1;
			for (int i = 0; i < EXT_BEATS; i++)
				exp_q.push_back({i == EXT_BEATS - 1, 8'hff, EXT_MARK | 64'(i)});
			@(negedge pcie_clk);
			while (!ext_tx_ack)
				@(negedge pcie_clk);
			@(posedge pcie_clk);
			fork
				send_copies(entry);
				begin
					// Release once the frames are in or the FIFO pushes back
					while (!frames_done && !saw_stall)
						@(negedge pcie_clk);
					repeat (8) @(posedge pcie_clk);
					send_ext_packet();
				end
			join
		end else begin
			send_copies(entry);
		end
		if (int'(entry.copies) * pay_words > `NETTLP_FIFO_DEPTH && !saw_stall) begin
			$display("the burst overfilled the FIFO but eth_tready never dropped");
			error_count++;
		end
		while (exp_q.size() != 0)
			@(posedge pcie_clk);
		repeat (SETTLE_CYCLES) @(posedge pcie_clk); // Gives stray beats time to show
		if (error_count == start_errors) begin
			entries_passed++;
			$display("entry %0d: ethertype %h port %0d len %0d ext %0d copies %0d ok",
				num, entry.ethertype, entry.udp_port, entry.len, entry.ext_hold, entry.copies);
		end else begin
			$display("entry %0d: ethertype %h port %0d len %0d ext %0d copies %0d FAILED",
				num, entry.ethertype, entry.udp_port, entry.len, entry.ext_hold, entry.copies);
		end
	endtask

	task automatic fill_table();
		frame_table[0]  = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd8, 1'b0, 1'b1, 4'd1};
		frame_table[1]  = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd13, 1'b0, 1'b1, 4'd1};
		frame_table[2]  = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd64, 1'b0, 1'b1, 4'd1};
		frame_table[3]  = '{16'h86dd, `NETTLP_UDP_PORT, 16'd32, 1'b0, 1'b0, 4'd1};
		frame_table[4]  = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd24, 1'b0, 1'b1, 4'd1};
		frame_table[5]  = '{`NETTLP_ETHERTYPE, 16'd3001, 16'd40, 1'b0, 1'b0, 4'd1};
		frame_table[6]  = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd16, 1'b0, 1'b1, 4'd1};
		frame_table[7]  = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd0, 1'b0, 1'b0, 4'd1};
		frame_table[8]  = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd100, 1'b0, 1'b1, 4'd1};
		frame_table[9]  = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd48, 1'b1, 1'b1, 4'd1};
		frame_table[10] = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd544, 1'b1, 1'b1, 4'd8};
		frame_table[11] = '{`NETTLP_ETHERTYPE, `NETTLP_UDP_PORT, 16'd13, 1'b0, 1'b1, 4'd1};
	endtask

	initial begin
		pcie_rst    = 1'b1;
		eth_tvalid  = 1'b0;
		eth_tdata   = '0;
		eth_tkeep   = '0;
		eth_tlast   = 1'b0;
		ext_tx_req  = 1'b0;
		ext_tvalid  = 1'b0;
		ext_tlast   = 1'b0;
		ext_tkeep   = '0;
		ext_tdata   = '0;
		pcie_tready = 1'b1;
		fill_table();
		timeout_limit = RESET_CYCLES;
		for (int e = 0; e < NUM_ENTRIES; e++)
			timeout_limit += int'(frame_table[e].copies) * frame_words(frame_table[e]) +
				SLACK_CYCLES;

		// Reset covers 16 rising edges, outputs are checked between them
		repeat (RESET_CYCLES - 1) begin
			@(negedge pcie_clk);
			check_value("pcie_tvalid", 64'd0, 64'(pcie_tvalid));
			check_value("ext_tx_ack", 64'd0, 64'(ext_tx_ack));
			check_value("eth_tready", 64'd0, 64'(eth_tready));
		end
		@(posedge pcie_clk);
		pcie_rst <= 1'b0;
		@(negedge pcie_clk);
		while (!eth_tready)
			@(negedge pcie_clk);
		check_value("pcie_tvalid", 64'd0, 64'(pcie_tvalid));
		check_value("ext_tx_ack", 64'd0, 64'(ext_tx_ack));
		if (error_count == 0)
			$display("reset: ok");
		else
			$display("reset: FAILED");

		for (int e = 0; e < NUM_ENTRIES; e++)
			run_entry(e, frame_table[e]);

		$display("%0d of %0d entries passed, %0d errors", entries_passed, NUM_ENTRIES,
			error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: nettlp_bridge.f
+incdir+design
design/nettlp_pkg.sv
design/eth_tlp_extract.sv
design/tlp_fifo.sv
design/fifo2pcie.sv
design/pcie_tx_arbiter.sv
design/nettlp_bridge.sv
dv/tb_nettlp_bridge.sv
